//--- src.f
+incdir+hw
hw/qar_pkg.sv
hw/qar_fetch.sv
hw/qar_regfile.sv
hw/qar_issue.sv
hw/qar_execute.sv
hw/qar_core.sv
test/tb_clock.sv
test/tb_qar_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the QAR core testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_qar_core -f src.f --Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_qar_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

//--- test/tb_qar_core.sv
/*
 * Testbench for the QAR core. Builds one program out of short tests, serves
 * both memory ports with random ready delays and checks each completed store.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_qar_core;

    typedef qar_pkg::word_t word_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    localparam word_t NOP         = 32'h0000_0013;   // ADDI x0, x0, 0
    localparam word_t SKIP_ADDR   = 32'h0000_03FC;   // Stores that a jump must skip
    localparam int    IDLE_CYCLES = 20;

    logic               clk;
    logic               rst_n;
    logic               imem_valid;
    word_t              imem_addr;
    logic               imem_ready = 1'b0;
    word_t              imem_rdata = '0;
    logic               mem_valid;
    qar_pkg::dmem_req_t mem_req;
    logic               mem_ready  = 1'b0;
    word_t              mem_rdata  = '0;

    word_t  prog [256];
    word_t  dmem [256];
    int     prog_len    = 0;
    int     store_slot  = 0;
    int     cycle_limit = 0;
    int     cycles      = 0;
    int     imem_wait   = -1;   // Cycles left before imem_ready, -1 when not drawn
    int     dmem_wait   = -1;
    word_t  lfsr_state  = 32'd72;
    store_t exp_q [$];
    string  name_q [$];

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    qar_core dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_valid (imem_valid),
        .imem_addr  (imem_addr),
        .imem_ready (imem_ready),
        .imem_rdata (imem_rdata),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

    // --------------------------------------------------
    // Random source and reference model
    // --------------------------------------------------
    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    // One LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Operation index 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl
    function automatic word_t ref_alu(input int op, input word_t a, input word_t b);
        case (op)
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return a << b[4:0];
            6:       return a >> b[4:0];
            default: return a + b;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // --------------------------------------------------
    // Instruction encoders
    // --------------------------------------------------
    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [4:0] rs1,
                                    input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input logic [2:0] f3,
                                    input logic [4:0] rs1, input logic [4:0] rs2);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                    input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // --------------------------------------------------
    // Checks and program building
    // --------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic emit(input word_t instr);
        prog[8'(prog_len)] = instr;
        prog_len++;
    endtask

    function automatic word_t next_pc();
        return word_t'(prog_len) << 2;
    endfunction

    function automatic word_t next_store_addr();
        return 32'h0000_0100 + (word_t'(store_slot) << 2);
    endfunction

    // LUI + ADDI, upper part rounded for the signed low half
    task automatic load_const(input logic [4:0] rd, input word_t value);
        word_t upper;
        upper = value + 32'h0000_0800;
        emit(enc_u(7'b0110111, rd, upper[31:12]));
        emit(enc_i(value[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    // SW of rs2 to the next free slot, with the value it must carry
    task automatic store_check(input string name, input logic [4:0] rs2, input word_t value);
        word_t addr;
        addr = next_store_addr();
        emit(enc_s(addr[11:0], rs2, 5'd0));
        exp_q.push_back(store_t'{addr, value});
        name_q.push_back(name);
        store_slot++;
    endtask

    task automatic add_alu_test(input string name, input int op, input logic [6:0] f7,
                                input logic [2:0] f3);
        word_t a;
        word_t b;
        a = rand_bits(32);
        b = rand_bits(32);
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_r(f7, f3, 5'd3, 5'd1, 5'd2));
        store_check(name, 5'd3, ref_alu(op, a, b));
    endtask

    task automatic add_upper_tests();
        word_t imm;
        word_t pc;
        imm = rand_bits(20);
        emit(enc_u(7'b0110111, 5'd4, imm[19:0]));
        store_check("lui", 5'd4, {imm[19:0], 12'h000});
        imm = rand_bits(12);
        emit(enc_i(imm[11:0], 5'd0, 3'b000, 5'd5, 7'b0010011));
        store_check("addi", 5'd5, {{20{imm[11]}}, imm[11:0]});
        imm = rand_bits(20);
        pc  = next_pc();
        emit(enc_u(7'b0010111, 5'd6, imm[19:0]));
        store_check("auipc", 5'd6, pc + {imm[19:0], 12'h000});
    endtask

    task automatic add_load_use_test();
        word_t v;
        word_t w;
        word_t addr;
        v = rand_bits(32);
        w = rand_bits(32);
        load_const(5'd7, v);
        load_const(5'd10, w);
        addr = next_store_addr();
        store_check("load-use store", 5'd7, v);
        emit(enc_i(addr[11:0], 5'd0, 3'b010, 5'd8, 7'b0000011));   // LW x8
        emit(enc_r(7'b0000000, 3'b000, 5'd9, 5'd8, 5'd10));        // Reads x8 at once
        store_check("load-use sum", 5'd9, v + w);
    endtask

    // x3 ends as 1 on the taken path, 0 on the fall-through path
    task automatic add_branch_test(input string name, input logic [2:0] f3);
        word_t a;
        word_t b;
        a = rand_bits(32);
        b = (rand_bits(1) != '0) ? a : rand_bits(32);
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_b(13'd12, f3, 5'd1, 5'd2));
        emit(enc_i(12'd0, 5'd0, 3'b000, 5'd3, 7'b0010011));
        emit(enc_j(5'd0, 21'd8));
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd3, 7'b0010011));
        store_check(name, 5'd3, {31'b0, ref_branch(f3, a, b)});
    endtask

    task automatic add_jump_tests();
        word_t pc;
        pc = next_pc();
        emit(enc_j(5'd11, 21'd8));
        emit(enc_s(SKIP_ADDR[11:0], 5'd0, 5'd0));   // Skipped by JAL
        store_check("jal link", 5'd11, pc + 32'd4);
        pc = next_pc() + 32'd8;                   // Where the JALR lands after LUI+ADDI
        load_const(5'd12, pc + 32'd4);
        emit(enc_i(12'd4, 5'd12, 3'b000, 5'd13, 7'b1100111));
        emit(enc_s(SKIP_ADDR[11:0], 5'd0, 5'd0));   // Skipped by JALR
        store_check("jalr link", 5'd13, pc + 32'd4);
    endtask

    // --------------------------------------------------
    // Memory models
    // --------------------------------------------------
    function automatic word_t imem_word(input word_t addr);
        if (addr[31:10] != '0) begin
            return NOP;
        end else begin
            return prog[addr[9:2]];
        end
    endfunction

    always @(posedge clk) begin
        #1;
        if (imem_ready) begin
            imem_ready = 1'b0;   // Handshake done at this edge
            imem_wait  = -1;
        end else if (imem_valid) begin
            if (imem_wait < 0) begin
                imem_wait = int'(rand_bits(2));
            end
            if (imem_wait == 0) begin
                imem_ready = 1'b1;
                imem_rdata = imem_word(imem_addr);
            end else begin
                imem_wait--;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (mem_ready) begin
            mem_ready = 1'b0;
            dmem_wait = -1;
        end else if (mem_valid) begin
            if (dmem_wait < 0) begin
                dmem_wait = int'(rand_bits(2));
            end
            if (dmem_wait == 0) begin
                mem_ready = 1'b1;
                mem_rdata = mem_req.we ? '0 : dmem[mem_req.addr[9:2]];
            end else begin
                dmem_wait--;
            end
        end
    end

    // Valid and ready both high at the falling edge means the store completes
    always @(negedge clk) begin : store_monitor
        store_t want;
        string  name;
        if (rst_n && mem_valid && mem_ready && mem_req.we) begin
            dmem[mem_req.addr[9:2]] = mem_req.wdata;
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Unexpected store of %h to address %h",
                                    mem_req.wdata, mem_req.addr));
            end else begin
                want = exp_q.pop_front();
                name = name_q.pop_front();
                check({name, " address"}, want.addr, mem_req.addr);
                check({name, " data"}, want.data, mem_req.wdata);
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (cycles > cycle_limit) begin
                if (exp_q.size() != 0) begin
                    abort_run($sformatf("Store for %s to address %h never appeared",
                                        name_q[0], exp_q[0].addr));
                end else begin
                    abort_run($sformatf("Run went past its limit of %0d cycles", cycle_limit));
                end
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        for (int i = 0; i < 256; i++) begin
            prog[8'(i)] = NOP;
            dmem[8'(i)] = 32'hD00D_0000 ^ (word_t'(i) << 2);   // Tagged by byte address
        end

        add_alu_test("add", 0, 7'b0000000, 3'b000);
        add_alu_test("sub", 1, 7'b0100000, 3'b000);
        add_alu_test("and", 2, 7'b0000000, 3'b111);
        add_alu_test("or", 3, 7'b0000000, 3'b110);
        add_alu_test("xor", 4, 7'b0000000, 3'b100);
        add_alu_test("sll", 5, 7'b0000000, 3'b001);
        add_alu_test("srl", 6, 7'b0000000, 3'b101);
        add_upper_tests();
        add_load_use_test();
        add_branch_test("beq", 3'b000);
        add_branch_test("bne", 3'b001);
        add_branch_test("blt", 3'b100);
        add_branch_test("bge", 3'b101);
        add_branch_test("bltu", 3'b110);
        add_branch_test("bgeu", 3'b111);
        add_jump_tests();
        emit(enc_j(5'd0, 21'd0));   // Park in a self-loop
        cycle_limit = 40 * prog_len + IDLE_CYCLES;

        @(posedge rst_n);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (IDLE_CYCLES) @(posedge clk);   // Room for a stray store to show up
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
/*
 * Clock and reset source for the QAR testbench.
 * 40 ns period; rst_n is held low for the first two rising edges.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;   // Released just after the edge, like the stimulus
    end

endmodule

`default_nettype wire

//--- hw/qar_core.sv
/*
 * Top level of the three-stage QAR core. Connects fetch, issue and
 * execute to the instruction and data memory ports.
 */
`timescale 1ns/100ps
`default_nettype none

module qar_core (
    input  logic               clk,
    input  logic               rst_n,

    // Instruction memory port
    output logic               imem_valid,
    output qar_pkg::word_t     imem_addr,
    input  logic               imem_ready,
    input  qar_pkg::word_t     imem_rdata,

    // Data memory port
    output logic               mem_valid,
    output qar_pkg::dmem_req_t mem_req,
    input  logic               mem_ready,
    input  qar_pkg::word_t     mem_rdata
);

    qar_pkg::fetch_item_t fetch_item;
    logic                 fetch_valid;
    logic                 fetch_accept;
    qar_pkg::issue_item_t issue_item;
    logic                 issue_valid;
    logic                 ex_busy;
    qar_pkg::rf_write_t   wb;
    qar_pkg::redirect_t   redirect;   // Taken branch or jump
    logic                 load_pending;
    qar_pkg::reg_idx_t    load_rd;

    qar_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .imem_valid  (imem_valid),
        .imem_addr   (imem_addr),
        .imem_ready  (imem_ready),
        .imem_rdata  (imem_rdata),
        .item        (fetch_item),
        .item_valid  (fetch_valid),
        .item_accept (fetch_accept)
    );

    qar_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_item      (fetch_item),
        .in_valid     (fetch_valid),
        .in_accept    (fetch_accept),
        .wb           (wb),
        .redirect     (redirect),
        .load_pending (load_pending),
        .load_rd      (load_rd),
        .out_item     (issue_item),
        .out_valid    (issue_valid),
        .ex_busy      (ex_busy)
    );

    qar_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .item         (issue_item),
        .item_valid   (issue_valid),
        .busy         (ex_busy),
        .wb           (wb),
        .redirect     (redirect),
        .load_pending (load_pending),
        .load_rd      (load_rd),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

//--- hw/qar_execute.sv
/*
 * Execute stage. Runs the ALU, resolves branches and jumps, drives the
 * data memory port for LW/SW and produces register write-back.
 */
`timescale 1ns/100ps
`default_nettype none

`include "qar_defines.svh"

module qar_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  qar_pkg::issue_item_t item,
    input  logic                 item_valid,
    output logic                 busy,
    output qar_pkg::rf_write_t   wb,
    output qar_pkg::redirect_t   redirect,
    output logic                 load_pending,
    output qar_pkg::reg_idx_t    load_rd,
    output logic                 mem_valid,
    output qar_pkg::dmem_req_t   mem_req,
    input  logic                 mem_ready,
    input  qar_pkg::word_t       mem_rdata
);

    function automatic qar_pkg::word_t imm_i(input qar_pkg::word_t instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic qar_pkg::word_t imm_s(input qar_pkg::word_t instr);
        return {{20{instr[31]}}, instr[31:25], instr[11:7]};
    endfunction

    qar_pkg::issue_item_t ex;
    logic                 ex_valid;
    logic                 accept;
    qar_pkg::opcode_e     in_opc;
    logic                 in_mem;     // Incoming LW or SW
    qar_pkg::opcode_e     opc;
    logic [2:0]           f3;
    logic [6:0]           f7;
    qar_pkg::word_t       pc_next;
    qar_pkg::word_t       alu_b;
    qar_pkg::word_t       alu_res;
    qar_pkg::alu_op_e     alu_op;
    logic                 alu_legal;
    logic                 taken;
    logic                 write;

    assign in_opc = qar_pkg::opcode_e'(item.instr[6:0]);
    assign in_mem = (in_opc == qar_pkg::OPC_LOAD || in_opc == qar_pkg::OPC_STORE) &&
                    item.instr[14:12] == 3'b010;

    assign busy   = mem_valid && !mem_ready;
    assign accept = item_valid && !busy && !redirect.valid;   // Flush drops the incoming item

    assign opc     = qar_pkg::opcode_e'(ex.instr[6:0]);
    assign f3      = ex.instr[14:12];
    assign f7      = ex.instr[31:25];
    assign pc_next = ex.pc + `QAR_PC_STEP;
    assign alu_b   = (opc == qar_pkg::OPC_OP) ? ex.rs2_val : imm_i(ex.instr);

    assign load_pending = mem_valid && !mem_req.we && !mem_ready;
    assign load_rd      = ex.instr[11:7];

    // --------------------------------------------------
    // ALU and branch compare
    // --------------------------------------------------
    always_comb begin
        alu_op    = qar_pkg::ALU_ADD;
        alu_legal = (f7 == 7'b0000000);
        if (opc == qar_pkg::OPC_OP) begin
            case (f3)
                3'b000: begin
                    if (f7 == 7'b0100000) begin
                        alu_op    = qar_pkg::ALU_SUB;
                        alu_legal = 1'b1;
                    end
                end
                3'b111:  alu_op = qar_pkg::ALU_AND;
                3'b110:  alu_op = qar_pkg::ALU_OR;
                3'b100:  alu_op = qar_pkg::ALU_XOR;
                3'b001:  alu_op = qar_pkg::ALU_SLL;
                3'b101:  alu_op = qar_pkg::ALU_SRL;
                default: alu_legal = 1'b0;   // SLT/SLTU not supported
            endcase
        end else begin
            alu_legal = (f3 == 3'b000);   // ADDI only
        end
    end

    always_comb begin
        case (alu_op)
            qar_pkg::ALU_SUB: alu_res = ex.rs1_val - alu_b;
            qar_pkg::ALU_AND: alu_res = ex.rs1_val & alu_b;
            qar_pkg::ALU_OR:  alu_res = ex.rs1_val | alu_b;
            qar_pkg::ALU_XOR: alu_res = ex.rs1_val ^ alu_b;
            qar_pkg::ALU_SLL: alu_res = ex.rs1_val << alu_b[4:0];
            qar_pkg::ALU_SRL: alu_res = ex.rs1_val >> alu_b[4:0];
            default:          alu_res = ex.rs1_val + alu_b;
        endcase
    end

    always_comb begin
        case (f3)
            3'b000:  taken = (ex.rs1_val == ex.rs2_val);
            3'b001:  taken = (ex.rs1_val != ex.rs2_val);
            3'b100:  taken = ($signed(ex.rs1_val) < $signed(ex.rs2_val));
            3'b101:  taken = ($signed(ex.rs1_val) >= $signed(ex.rs2_val));
            3'b110:  taken = (ex.rs1_val < ex.rs2_val);
            3'b111:  taken = (ex.rs1_val >= ex.rs2_val);
            default: taken = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Write-back and redirect
    // --------------------------------------------------
    always_comb begin
        write    = 1'b0;
        wb.addr  = ex.instr[11:7];
        wb.data  = alu_res;
        redirect = '0;
        if (ex_valid) begin
            case (opc)
                qar_pkg::OPC_OP, qar_pkg::OPC_OP_IMM: write = alu_legal;
                qar_pkg::OPC_LUI: begin
                    write   = 1'b1;
                    wb.data = {ex.instr[31:12], 12'b0};
                end
                qar_pkg::OPC_AUIPC: begin
                    write   = 1'b1;
                    wb.data = ex.pc + {ex.instr[31:12], 12'b0};
                end
                qar_pkg::OPC_JAL: begin
                    write           = 1'b1;
                    wb.data         = pc_next;
                    redirect.valid  = 1'b1;
                    redirect.target = ex.pc + {{12{ex.instr[31]}}, ex.instr[19:12],
                                               ex.instr[20], ex.instr[30:21], 1'b0};
                end
                qar_pkg::OPC_JALR: begin
                    write           = (f3 == 3'b000);
                    wb.data         = pc_next;
                    redirect.valid  = (f3 == 3'b000);
                    redirect.target = (ex.rs1_val + imm_i(ex.instr)) & ~32'd1;
                end
                qar_pkg::OPC_BRANCH: begin
                    redirect.valid  = taken;
                    redirect.target = ex.pc + {{20{ex.instr[31]}}, ex.instr[7],
                                               ex.instr[30:25], ex.instr[11:8], 1'b0};
                end
                qar_pkg::OPC_LOAD: begin
                    write   = mem_valid && mem_ready;   // Completion cycle only
                    wb.data = mem_rdata;
                end
                default: ;   // Stores and unknown encodings write nothing
            endcase
        end
        wb.en = write && wb.addr != '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            if (!busy) begin
                ex_valid <= accept;
            end
            if (accept && in_mem) begin
                mem_valid <= 1'b1;
            end else if (mem_ready) begin
                mem_valid <= 1'b0;
            end
        end
    end

    // Request is built from the incoming item so mem_valid rises with it
    always_ff @(posedge clk) begin
        if (accept) begin
            ex            <= item;
            mem_req.we    <= (in_opc == qar_pkg::OPC_STORE);
            mem_req.addr  <= item.rs1_val + ((in_opc == qar_pkg::OPC_STORE) ?
                                             imm_s(item.instr) : imm_i(item.instr));
            mem_req.wdata <= item.rs2_val;
        end
    end

endmodule

`default_nettype wire

//--- hw/qar_issue.sv
/*
 * Decode/issue stage. Buffers one fetched instruction, reads its source
 * operands with forwarding from write-back, and holds on load-use hazards.
 */
`timescale 1ns/100ps
`default_nettype none

module qar_issue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  qar_pkg::fetch_item_t in_item,
    input  logic                 in_valid,
    output logic                 in_accept,
    input  qar_pkg::rf_write_t   wb,
    input  qar_pkg::redirect_t   redirect,
    input  logic                 load_pending,
    input  qar_pkg::reg_idx_t    load_rd,
    output qar_pkg::issue_item_t out_item,
    output logic                 out_valid,
    input  logic                 ex_busy
);

    qar_pkg::fetch_item_t held;
    logic                 held_valid;
    qar_pkg::opcode_e     opc;
    qar_pkg::reg_idx_t    rs1;
    qar_pkg::reg_idx_t    rs2;
    qar_pkg::word_t       rf_rdata1;
    qar_pkg::word_t       rf_rdata2;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 hazard;

    assign opc = qar_pkg::opcode_e'(held.instr[6:0]);
    assign rs1 = held.instr[19:15];
    assign rs2 = held.instr[24:20];

    // Which sources the opcode actually reads
    assign uses_rs1 = opc inside {qar_pkg::OPC_OP, qar_pkg::OPC_OP_IMM, qar_pkg::OPC_LOAD,
                                  qar_pkg::OPC_STORE, qar_pkg::OPC_BRANCH, qar_pkg::OPC_JALR};
    assign uses_rs2 = opc inside {qar_pkg::OPC_OP, qar_pkg::OPC_STORE, qar_pkg::OPC_BRANCH};

    qar_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (wb),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // --------------------------------------------------
    // Hazard and operand selection
    // --------------------------------------------------
    assign hazard = load_pending &&
                    ((uses_rs1 && rs1 != '0 && rs1 == load_rd) ||
                     (uses_rs2 && rs2 != '0 && rs2 == load_rd));

    always_comb begin
        out_item.pc      = held.pc;
        out_item.instr   = held.instr;
        out_item.rs1_val = (uses_rs1 && wb.en && wb.addr == rs1) ? wb.data : rf_rdata1;
        out_item.rs2_val = (uses_rs2 && wb.en && wb.addr == rs2) ? wb.data : rf_rdata2;
    end

    assign out_valid = held_valid && !hazard;
    assign in_accept = !held_valid || (out_valid && !ex_busy);   // Empty or leaving

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (redirect.valid) begin
            held_valid <= 1'b0;
        end else if (in_accept) begin
            held_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_accept && in_valid) begin
            held <= in_item;
        end
    end

endmodule

`default_nettype wire

//--- hw/qar_regfile.sv
/*
 * Integer register file, two asynchronous read ports and one write port.
 * x0 ignores writes and always reads as zero.
 */
`timescale 1ns/100ps
`default_nettype none

`include "qar_defines.svh"

module qar_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  qar_pkg::rf_write_t  wr,
    input  qar_pkg::reg_idx_t   raddr1,
    input  qar_pkg::reg_idx_t   raddr2,
    output qar_pkg::word_t      rdata1,
    output qar_pkg::word_t      rdata2
);

    qar_pkg::word_t regs [`QAR_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `QAR_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hw/qar_fetch.sv
/*
 * Fetch stage. Keeps one request in flight on the instruction port and
 * hands each answer on through a one-entry slot; redirects restart it.
 */
`timescale 1ns/100ps
`default_nettype none

`include "qar_defines.svh"

module qar_fetch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  qar_pkg::redirect_t   redirect,
    output logic                 imem_valid,
    output qar_pkg::word_t       imem_addr,
    input  logic                 imem_ready,
    input  qar_pkg::word_t       imem_rdata,
    output qar_pkg::fetch_item_t item,
    output logic                 item_valid,
    input  logic                 item_accept
);

    qar_pkg::word_t pc;   // Next address to request
    logic pending;        // Request outstanding on imem
    logic discard;        // Answer belongs to a flushed path
    logic answer;
    logic launch;

    assign imem_valid = pending;
    assign answer     = pending && imem_ready;
    assign launch     = !pending && (!item_valid || item_accept) && !redirect.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= `QAR_RESET_PC;
            imem_addr  <= `QAR_RESET_PC;
            pending    <= 1'b0;
            discard    <= 1'b0;
            item_valid <= 1'b0;
        end else begin
            if (pending) begin
                if (imem_ready) begin
                    pending <= 1'b0;
                    discard <= 1'b0;
                end else if (redirect.valid) begin
                    discard <= 1'b1;   // Address must stay put until ready
                end
            end else if (launch) begin
                pending   <= 1'b1;
                imem_addr <= pc;
                pc        <= pc + `QAR_PC_STEP;
            end

            if (redirect.valid) begin
                pc         <= redirect.target;
                item_valid <= 1'b0;
            end else if (answer && !discard) begin
                item_valid <= 1'b1;
            end else if (item_accept) begin
                item_valid <= 1'b0;
            end
        end
    end

    // Slot payload
    always_ff @(posedge clk) begin
        if (answer && !discard) begin
            item.pc    <= imem_addr;
            item.instr <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/qar_pkg.sv
/*
 * Shared types for the QAR core: words, register indices, opcode and
 * ALU encodings, and the items passed between pipeline stages.
 */
`default_nettype none

`include "qar_defines.svh"

package qar_pkg;

    typedef logic [`QAR_XLEN-1:0] word_t;
    typedef logic [$clog2(`QAR_REG_COUNT)-1:0] reg_idx_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL
    } alu_op_e;

    // --------------------------------------------------
    // Stage items
    // --------------------------------------------------
    typedef struct packed { word_t pc; word_t instr; } fetch_item_t;
    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t rs1_val;
        word_t rs2_val;
    } issue_item_t;
    typedef struct packed { logic en; reg_idx_t addr; word_t data; } rf_write_t;
    typedef struct packed { logic valid; word_t target; } redirect_t;   // Flush + new PC
    typedef struct packed { logic we; word_t addr; word_t wdata; } dmem_req_t;

endpackage

`default_nettype wire

//--- hw/qar_defines.svh
/*
 * Core-wide constants for the QAR pipeline, fixed by the RV32I ISA.
 * Included by the package and by any module that needs a raw value.
 */
`ifndef QAR_DEFINES_SVH
`define QAR_DEFINES_SVH

// Data and address width
`define QAR_XLEN 32

// Architectural registers, x0 included
`define QAR_REG_COUNT 32

`define QAR_RESET_PC 32'h0000_0000   // First fetch address
`define QAR_PC_STEP  32'd4           // Bytes per instruction

`endif
